//--- rtl/logger_defines.svh
`ifndef LOGGER_DEFINES_SVH
`define LOGGER_DEFINES_SVH

`define LOGGER_WORD_W        16
`define LOGGER_DEPTH         256
`define LOGGER_ADDR_W        8
`define LOGGER_POST_WORDS    128
`define LOGGER_WIN_LEN       256
`define LOGGER_LEVEL_THRESH  96

// default bit time for simulation
`define LOGGER_CLKS_PER_BIT  8

`endif

//--- rtl/logger_pkg.sv
`include "logger_defines.svh"

package logger_pkg;

    // first sample sits in the msb
    typedef logic [`LOGGER_WORD_W-1:0] word_t;

    typedef logic [`LOGGER_ADDR_W-1:0] addr_t;

    // serial payload
    typedef logic [7:0] byte_t;

    // ones per window saturating at 255
    typedef logic [7:0] density_t;

endpackage

//--- rtl/bit_capture.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module bit_capture (
    input  logic               clk,
    input  logic               rst,
    input  logic               sig,
    output logger_pkg::word_t  word,
    output logic               word_stb
);

    localparam int CNT_W = $clog2(`LOGGER_WORD_W);

    logic [CNT_W-1:0]  bit_cnt;
    logger_pkg::word_t shift;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt  <= '0;
            shift    <= '0;
            word     <= '0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= 1'b0;
            shift    <= {shift[`LOGGER_WORD_W-2:0], sig};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(`LOGGER_WORD_W - 1)) begin
                word     <= {shift[`LOGGER_WORD_W-2:0], sig};
                word_stb <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/density_demod.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module density_demod (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sig,
    output logger_pkg::density_t  density,
    output logic                  level
);

    localparam int WIN_W = $clog2(`LOGGER_WIN_LEN);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`LOGGER_WIN_LEN - 1);
    localparam logger_pkg::density_t THRESH = 8'(`LOGGER_LEVEL_THRESH);

    logic [WIN_W-1:0]     win_cnt;
    logger_pkg::density_t ones;
    logger_pkg::density_t ones_next;

    always_comb begin
        ones_next = ones;
        if (sig && (ones != '1)) begin  // saturate
            ones_next = ones + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            win_cnt <= '0;
            ones    <= '0;
            density <= '0;
            level   <= 1'b0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (win_cnt == WIN_LAST) begin
                density <= ones_next;  // includes the last sample
                level   <= (ones_next >= THRESH);
                ones    <= '0;
            end else begin
                ones <= ones_next;
            end
        end
    end

endmodule

//--- rtl/sample_ram.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module sample_ram (
    input  logic               clk,
    input  logic               wr_en,
    input  logger_pkg::addr_t  wr_addr,
    input  logger_pkg::word_t  wr_data,
    input  logger_pkg::addr_t  rd_addr,
    output logger_pkg::word_t  rd_data
);

    logger_pkg::word_t mem [0:`LOGGER_DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read like block ram
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- rtl/dump_ctrl.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module dump_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               arm,
    input  logger_pkg::word_t  word,
    input  logic               word_stb,
    output logic               wr_en,
    output logger_pkg::addr_t  wr_addr,
    output logger_pkg::word_t  wr_data,
    output logger_pkg::addr_t  rd_addr,
    input  logger_pkg::word_t  rd_data,
    output logger_pkg::byte_t  tx_data,
    output logic               tx_start,
    input  logic               tx_busy,
    output logic               busy,
    output logic               done
);

    localparam int POST_W = $clog2(`LOGGER_POST_WORDS);
    localparam logic [POST_W-1:0] POST_LAST = POST_W'(`LOGGER_POST_WORDS - 1);
    localparam logger_pkg::addr_t ADDR_LAST = `LOGGER_ADDR_W'(`LOGGER_DEPTH - 1);

    typedef enum logic [2:0] {
        S_REC,
        S_POST,
        S_READ,
        S_HIGH,
        S_LOW,
        S_FINISH
    } state_t;

    state_t            state;
    logger_pkg::addr_t wr_ptr;
    logger_pkg::addr_t dump_addr;
    logger_pkg::addr_t sent_cnt;
    logic [POST_W-1:0] post_cnt;
    logger_pkg::byte_t low_byte;
    logic              tx_free;

    assign wr_en   = word_stb && ((state == S_REC) || (state == S_POST));
    assign wr_addr = wr_ptr;
    assign wr_data = word;
    assign rd_addr = dump_addr;
    assign busy    = (state != S_REC);

    // tx_busy rises the cycle tx_start drops
    assign tx_free = !tx_busy && !tx_start;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= S_REC;
            wr_ptr    <= '0;
            dump_addr <= '0;
            sent_cnt  <= '0;
            post_cnt  <= '0;
            tx_start  <= 1'b0;
            done      <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            done     <= 1'b0;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case (state)
                S_REC: begin
                    if (arm) begin
                        post_cnt <= '0;
                        state    <= S_POST;
                    end
                end
                S_POST: begin
                    if (word_stb) begin
                        post_cnt <= post_cnt + 1'b1;
                        if (post_cnt == POST_LAST) begin
                            dump_addr <= wr_ptr + 1'b1;  // oldest word
                            sent_cnt  <= '0;
                            state     <= S_READ;
                        end
                    end
                end
                S_READ: state <= S_HIGH;  // ram latency
                S_HIGH: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        state    <= S_LOW;
                    end
                end
                S_LOW: begin
                    if (tx_free) begin
                        tx_start  <= 1'b1;
                        dump_addr <= dump_addr + 1'b1;
                        sent_cnt  <= sent_cnt + 1'b1;
                        state     <= (sent_cnt == ADDR_LAST) ? S_FINISH : S_READ;
                    end
                end
                S_FINISH: begin
                    if (tx_free) begin  // last stop bit done
                        done  <= 1'b1;
                        state <= S_REC;
                    end
                end
                default: state <= S_REC;
            endcase
        end
    end

    // byte payload to the transmitter
    always_ff @(posedge clk) begin
        if ((state == S_HIGH) && tx_free) begin
            tx_data  <= rd_data[15:8];
            low_byte <= rd_data[7:0];
        end else if ((state == S_LOW) && tx_free) begin
            tx_data <= low_byte;
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module uart_tx #(
    parameter int CLKS_PER_BIT = `LOGGER_CLKS_PER_BIT
) (
    input  logic               clk,
    input  logic               rst,
    input  logger_pkg::byte_t  tx_data,
    input  logic               tx_start,
    output logic               tx,
    output logic               tx_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] rate_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       frame;  // stop, data lsb first, start

    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            rate_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= '1;  // line idles high
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};
                rate_cnt <= '0;
                bit_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (rate_cnt == CNT_LAST) begin
            rate_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin  // end of stop bit
                tx_busy <= 1'b0;
            end
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/sig_logger_top.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module sig_logger_top #(
    parameter int CLKS_PER_BIT = `LOGGER_CLKS_PER_BIT
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sig,
    input  logic                  arm,
    output logic                  tx,
    output logic                  busy,
    output logic                  done,
    output logger_pkg::density_t  density,
    output logic                  level
);

    logger_pkg::word_t word;
    logic              word_stb;
    logic              wr_en;
    logger_pkg::addr_t wr_addr;
    logger_pkg::word_t wr_data;
    logger_pkg::addr_t rd_addr;
    logger_pkg::word_t rd_data;
    logger_pkg::byte_t tx_data;
    logic              tx_start;
    logic              tx_busy;

    bit_capture capture_i (
        .clk      (clk),
        .rst      (rst),
        .sig      (sig),
        .word     (word),
        .word_stb (word_stb)
    );

    density_demod demod_i (
        .clk     (clk),
        .rst     (rst),
        .sig     (sig),
        .density (density),
        .level   (level)
    );

    sample_ram ram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dump_ctrl dump_i (
        .clk      (clk),
        .rst      (rst),
        .arm      (arm),
        .word     (word),
        .word_stb (word_stb),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .busy     (busy),
        .done     (done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

//--- dv/tb_sig_logger.sv
`timescale 1ns/10ps
`include "logger_defines.svh"

module tb_sig_logger;

    localparam int CPB    = `LOGGER_CLKS_PER_BIT;
    localparam int NBYTES = 2 * `LOGGER_DEPTH;
    localparam int WW     = `LOGGER_WORD_W;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 sig;
    logic                 arm;
    logic                 tx;
    logic                 busy;
    logic                 done;
    logger_pkg::density_t density;
    logic                 level;

    int                   seed;
    int                   val_errs;
    int                   other_errs;
    int                   sample_cnt = 0;
    int                   arm_edges[$];  // sample index of each arm the dut sees
    logger_pkg::word_t    shadow = '0;
    logger_pkg::word_t    word_hist[$];
    logger_pkg::byte_t    rx_bytes[NBYTES];

    sig_logger_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .sig     (sig),
        .arm     (arm),
        .tx      (tx),
        .busy    (busy),
        .done    (done),
        .density (density),
        .level   (level)
    );

    always #50 clk = ~clk;

    // shadow words built from the samples the dut takes
    always @(posedge clk) begin
        if (rst) begin
            shadow = {shadow[WW-2:0], sig};
            if (sample_cnt % WW == WW - 1) begin
                word_hist.push_back(shadow);
            end
            if (arm) begin
                arm_edges.push_back(sample_cnt);
            end
            sample_cnt <= sample_cnt + 1;
        end
    end

    task automatic check_byte(input logger_pkg::byte_t got, input logger_pkg::byte_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_density(input logger_pkg::density_t got,
                                 input logger_pkg::density_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic drive_random(input int n);
        int rnd;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            rnd = $random(seed);
            sig <= rnd[0];
        end
    endtask

    // period p drives a 1 every p samples and period 0 drives zeros
    task automatic drive_pattern(input int period, input int n);
        bit aligned;
        aligned = 1'b0;
        for (int i = 0; i <= `LOGGER_WIN_LEN && !aligned; i++) begin
            @(posedge clk);
            if ((sample_cnt + 1) % `LOGGER_WIN_LEN == 0) begin
                aligned = 1'b1;
            end
        end
        if (!aligned) begin
            $display("density window boundary was never reached");
            other_errs++;
            return;
        end
        for (int i = 0; i < n; i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            if (period == 0) begin
                sig <= 1'b0;
            end else begin
                sig <= (i % period == 0);
            end
        end
    endtask

    task automatic expect_density(input logger_pkg::density_t exp_d, input logic exp_lvl,
                                  input string tag);
        repeat (3) @(posedge clk);  // last sample, latch, settle
        check_density(density, exp_d, {tag, " density"});
        check_bit(level, exp_lvl, {tag, " level"});
    endtask

    // 8N1 receiver sampling each bit at its middle
    task automatic receive_byte(output logger_pkg::byte_t b, output bit ok, input int limit);
        bit found;
        found = 1'b0;
        b     = '0;
        for (int i = 0; i < limit && !found; i++) begin
            @(posedge clk);
            if (tx == 1'b0) begin
                found = 1'b1;
            end
        end
        ok = found;
        if (!found) begin
            $display("no start bit arrived on tx within %0d clocks", limit);
            other_errs++;
            return;
        end
        repeat (CPB / 2) @(posedge clk);
        check_bit(tx, 1'b0, "start bit at mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(posedge clk);
            b[i] = tx;  // lsb first
        end
        repeat (CPB) @(posedge clk);
        check_bit(tx, 1'b1, "stop bit");
    endtask

    task automatic wait_done(output bit ok);
        bit extra;
        ok    = 1'b0;
        extra = 1'b0;
        for (int i = 0; i < 20 * CPB + 100 && !ok && !extra; i++) begin
            @(posedge clk);
            if (done) begin
                ok = 1'b1;
            end else if (tx == 1'b0) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            $display("a start bit beyond byte %0d appeared on tx before done", NBYTES);
            other_errs++;
        end else if (!ok) begin
            $display("done did not pulse after the last byte of the dump");
            other_errs++;
        end
    endtask

    task automatic expect_quiet_line(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (tx == 1'b0) begin
                $display("an extra byte started on tx after the dump at %0t", $time);
                other_errs++;
                return;
            end
        end
    endtask

    // pre-fill, arm, receive 512 bytes and compare with the shadow words
    task automatic capture_dump(input bit poke_arm, input string tag);
        int                arm_idx;
        int                last_word;
        int                first_word;
        bit                ok;
        logger_pkg::word_t w;
        logger_pkg::byte_t b;
        arm_idx = arm_edges.size();
        drive_random(300 * WW);
        @(posedge clk);
        arm <= 1'b1;
        @(posedge clk);
        arm <= 1'b0;
        drive_random(120 * WW);  // ends before the post-count does
        ok = 1'b1;
        for (int i = 0; i < NBYTES && ok; i++) begin
            receive_byte(b, ok, (i == 0) ? 40 * WW : 20 * CPB + 50);
            rx_bytes[i] = b;
            if (ok && i == 0) begin
                check_bit(busy, 1'b1, {tag, " busy during dump"});
            end
            if (poke_arm && i == 100) begin
                @(posedge clk);
                arm <= 1'b1;  // must not restart the dump
                @(posedge clk);
                arm <= 1'b0;
            end
        end
        if (!ok) begin
            return;
        end
        if (arm_edges.size() <= arm_idx) begin
            $display("%s: the arm pulse never reached the DUT", tag);
            other_errs++;
            return;
        end
        // word k strobes at sample 16k+16 and only strobes after the arm edge count
        last_word  = arm_edges[arm_idx] / WW + `LOGGER_POST_WORDS - 1;
        first_word = last_word - (`LOGGER_DEPTH - 1);
        if (first_word < 0 || last_word >= word_hist.size()) begin
            $display("%s: not enough shadow words to build the expected dump", tag);
            other_errs++;
            return;
        end
        for (int k = 0; k < `LOGGER_DEPTH; k++) begin
            w = word_hist[first_word + k];
            check_byte(rx_bytes[2*k], w[15:8], $sformatf("%s byte %0d", tag, 2*k));
            check_byte(rx_bytes[2*k+1], w[7:0], $sformatf("%s byte %0d", tag, 2*k+1));
        end
        wait_done(ok);
        if (ok) begin
            check_bit(busy, 1'b0, {tag, " busy after done"});
            expect_quiet_line(30 * CPB);
        end
    endtask

    task automatic reset_state();
        repeat (2) @(posedge clk);
        check_bit(tx, 1'b1, "tx after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(done, 1'b0, "done after reset");
        check_density(density, 8'd0, "density after reset");
        check_bit(level, 1'b0, "level after reset");
    endtask

    task automatic constant_density();
        drive_pattern(1, 2 * `LOGGER_WIN_LEN);
        expect_density(8'd255, 1'b1, "constant one");
        drive_pattern(0, 2 * `LOGGER_WIN_LEN);
        expect_density(8'd0, 1'b0, "constant zero");
    endtask

    task automatic density_threshold();
        drive_pattern(2, 2 * `LOGGER_WIN_LEN);
        expect_density(8'd128, 1'b1, "every second");
        drive_pattern(4, 2 * `LOGGER_WIN_LEN);
        expect_density(8'd64, 1'b0, "every fourth");
    endtask

    task automatic dump_contents();
        capture_dump(1'b0, "dump 1");
    endtask

    task automatic rearm_capture();
        capture_dump(1'b1, "dump 2");
    endtask

    initial begin
        seed       = 52;
        val_errs   = 0;
        other_errs = 0;
        rst        = 1'b0;
        sig        = 1'b0;
        arm        = 1'b0;
        apply_reset();
        reset_state();
        constant_density();
        density_threshold();
        dump_contents();
        rearm_capture();
        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/logger_pkg.sv
rtl/bit_capture.sv
rtl/density_demod.sv
rtl/sample_ram.sv
rtl/dump_ctrl.sv
rtl/uart_tx.sv
rtl/sig_logger_top.sv
dv/tb_sig_logger.sv

//--- run.sh
#!/bin/sh
# compile and run the logger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_sig_logger \
    --Mdir obj_dir -o sim_logger

./obj_dir/sim_logger | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
